//--- hw/decode_pkg.sv
// Shared types and constants for the RV32IM decode stage.
// Imported by every RTL block of the stage. Holds the field widths,
// the opcode and functional-unit encodings, and the write-port
// latencies used by the write-back conflict tracker.
package decode_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP      = 7'b0110011,
    OP_IMM  = 7'b0010011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    MISCMEM = 7'b0001111
  } opcode_t;

  typedef enum logic [1:0] {
    FU_ALU = 2'd0,
    FU_MUL = 2'd1,
    FU_DIV = 2'd2,
    FU_LSU = 2'd3
  } fu_class_t;

  typedef enum logic [1:0] {
    SRC_A_RS1  = 2'd0,
    SRC_A_PC   = 2'd1,
    SRC_A_ZERO = 2'd2
  } src_a_sel_t;

  typedef enum logic [1:0] {
    SRC_B_RS2   = 2'd0,
    SRC_B_IMM   = 2'd1,
    SRC_B_IMM_U = 2'd2
  } src_b_sel_t;

  // MUL, DIV and LSU reuse the low values to carry funct3
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_op_t;

  // Cycles from issue to the shared write port
  localparam int ALU_LATENCY      = 0;
  localparam int MUL_LATENCY      = 3;
  localparam int DIV_LATENCY      = 17;
  localparam int DIV_FAST_LATENCY = 0;

  localparam int WB_SLOTS = DIV_LATENCY + 1;

endpackage

//--- hw/instr_decoder.sv
// Combinational RV32IM instruction decoder.
// Splits the instruction into register indexes and sign-extended
// immediates, and picks the functional-unit class, ALU operation and
// operand sources. Branches are handed to the ALU as compare ops.
`timescale 1ns/1ps

module instr_decoder (
  input  decode_pkg::word_t      instr,
  output decode_pkg::opcode_t    opcode,
  output decode_pkg::fu_class_t  fu_class,
  output decode_pkg::alu_op_t    alu_op,
  output decode_pkg::src_a_sel_t src_a_sel,
  output decode_pkg::src_b_sel_t src_b_sel,
  output decode_pkg::reg_idx_t   rs1_idx,
  output decode_pkg::reg_idx_t   rs2_idx,
  output decode_pkg::reg_idx_t   rd,
  output logic                   wen,
  output logic                   is_jump,
  output logic                   is_jalr,
  output logic                   is_store,
  output logic                   is_fence,
  output logic                   illegal,
  output decode_pkg::word_t      imm,
  output decode_pkg::word_t      imm_j
);

  import decode_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;
  logic       wen_dec;

  // Register-register and register-immediate ALU mapping
  function automatic alu_op_t alu_fn(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      3'b000:  op = alt ? SUB : ADD;
      3'b001:  op = SLL;
      3'b010:  op = SLT;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = alt ? SRA : SRL;
      3'b110:  op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  assign opcode  = opcode_t'(instr[6:0]);
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign rd      = instr[11:7];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    fu_class  = FU_ALU;
    alu_op    = ADD;
    src_a_sel = SRC_A_RS1;
    src_b_sel = SRC_B_RS2;
    imm       = imm_i;
    wen_dec   = 1'b0;
    is_jump   = 1'b0;
    is_jalr   = 1'b0;
    is_store  = 1'b0;
    is_fence  = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      OP: begin
        wen_dec = 1'b1;
        if (funct7 == 7'b0000001) begin
          // M extension, funct3[2] splits multiply from divide
          fu_class = funct3[2] ? FU_DIV : FU_MUL;
          alu_op   = alu_op_t'({1'b0, funct3});
        end else begin
          alu_op = alu_fn(funct3, funct7[5]);
        end
      end
      OP_IMM: begin
        wen_dec   = 1'b1;
        src_b_sel = SRC_B_IMM;
        alu_op    = alu_fn(funct3, (funct3 == 3'b101) && funct7[5]);
        // Shift amount replaces the I immediate
        if (funct3[1:0] == 2'b01) begin
          imm = {27'b0, instr[24:20]};
        end
      end
      LOAD: begin
        fu_class  = FU_LSU;
        alu_op    = alu_op_t'({1'b0, funct3});
        src_b_sel = SRC_B_IMM;
        wen_dec   = 1'b1;
      end
      STORE: begin
        fu_class  = FU_LSU;
        alu_op    = alu_op_t'({1'b0, funct3});
        src_b_sel = SRC_B_IMM;
        imm       = imm_s;
        is_store  = 1'b1;
      end
      LUI: begin
        src_a_sel = SRC_A_ZERO;
        src_b_sel = SRC_B_IMM_U;
        imm       = imm_u;
        wen_dec   = 1'b1;
      end
      AUIPC: begin
        src_a_sel = SRC_A_PC;
        src_b_sel = SRC_B_IMM_U;
        imm       = imm_u;
        wen_dec   = 1'b1;
      end
      JAL: begin
        src_a_sel = SRC_A_PC;
        wen_dec   = 1'b1;
        is_jump   = 1'b1;
      end
      JALR: begin
        src_b_sel = SRC_B_IMM;
        wen_dec   = 1'b1;
        is_jump   = 1'b1;
        is_jalr   = 1'b1;
      end
      BRANCH: begin
        case (funct3[2:1])
          2'b10:   alu_op = SLT;
          2'b11:   alu_op = SLTU;
          default: alu_op = SUB;
        endcase
      end
      MISCMEM: begin
        is_fence = (funct3 == 3'b001);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  assign wen = wen_dec & ~illegal;

endmodule

//--- hw/operand_select.sv
// Operand and jump target selection for the decode stage.
// Bypass data overrides the register file read, then the decoded
// selects pick source A and B. JAL targets use pc plus the J
// immediate, JALR targets use rs1 plus the I immediate.
`timescale 1ns/1ps

module operand_select (
  input  decode_pkg::src_a_sel_t src_a_sel,
  input  decode_pkg::src_b_sel_t src_b_sel,
  input  decode_pkg::word_t      rs1_data,
  input  decode_pkg::word_t      rs2_data,
  input  logic                   rs1_bypass_ena,
  input  logic                   rs2_bypass_ena,
  input  decode_pkg::word_t      rs1_bypass_data,
  input  decode_pkg::word_t      rs2_bypass_data,
  input  decode_pkg::word_t      pc,
  input  decode_pkg::word_t      imm,
  input  decode_pkg::word_t      imm_j,
  input  logic                   is_jalr,
  output decode_pkg::word_t      port_a,
  output decode_pkg::word_t      port_b,
  output decode_pkg::word_t      store_data,
  output decode_pkg::word_t      jump_target
);

  import decode_pkg::*;

  word_t rs1_val;
  word_t rs2_val;
  word_t jalr_sum;

  assign rs1_val = rs1_bypass_ena ? rs1_bypass_data : rs1_data;
  assign rs2_val = rs2_bypass_ena ? rs2_bypass_data : rs2_data;

  always_comb begin
    case (src_a_sel)
      SRC_A_RS1: port_a = rs1_val;
      SRC_A_PC:  port_a = pc;
      default:   port_a = '0;
    endcase
  end

  always_comb begin
    case (src_b_sel)
      SRC_B_RS2:   port_b = rs2_val;
      SRC_B_IMM:   port_b = imm;
      SRC_B_IMM_U: port_b = {imm[XLEN-1:12], 12'b0};
      default:     port_b = '0;
    endcase
  end

  assign store_data = rs2_val;

  // JALR clears bit 0 of the sum
  assign jalr_sum    = rs1_val + imm;
  assign jump_target = is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm_j;

endmodule

//--- hw/wb_conflict_tracker.sv
// Write-back port scoreboard for the shared ALU/MUL/DIV result port.
// Each bit marks a cycle in which the port is already claimed. The
// vector shifts down every cycle, and an issued instruction claims the
// bit that matches its latency. LSU results have their own port.
`timescale 1ns/1ps

module wb_conflict_tracker (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  issue,
  input  decode_pkg::fu_class_t fu_class,
  input  decode_pkg::word_t     port_a,
  input  decode_pkg::word_t     port_b,
  output logic                  wb_conflict
);

  import decode_pkg::*;

  logic [WB_SLOTS-1:0] claims;
  logic [WB_SLOTS-1:0] claim_bit;
  logic                div_fast;
  logic                takes_slot;
  int unsigned         lat;

  // Divide by zero and signed overflow finish without iterating
  assign div_fast = (port_b == '0) ||
                    ((port_a == {1'b1, {(XLEN-1){1'b0}}}) && (port_b == '1));

  always_comb begin
    takes_slot = 1'b1;
    case (fu_class)
      FU_MUL:  lat = MUL_LATENCY;
      FU_DIV:  lat = div_fast ? DIV_FAST_LATENCY : DIV_LATENCY;
      FU_LSU: begin
        lat        = ALU_LATENCY;
        takes_slot = 1'b0;
      end
      default: lat = ALU_LATENCY;
    endcase
  end

  assign claim_bit   = {{(WB_SLOTS-1){1'b0}}, 1'b1} << lat;
  assign wb_conflict = takes_slot && claims[lat];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      claims <= '0;
    end else if (issue && takes_slot) begin
      claims <= (claims | claim_bit) >> 1;
    end else begin
      claims <= claims >> 1;
    end
  end

endmodule

//--- hw/fence_tracker.sv
// FENCE.I handling toward the instruction and data caches.
// An issued fence sends a one-cycle flush to both caches and keeps
// the stage busy until each cache has reported its flush done.
`timescale 1ns/1ps

module fence_tracker (
  input  logic CLK,
  input  logic nRST,
  input  logic issue,
  input  logic is_fence,
  input  logic iflush_done,
  input  logic dflush_done,
  output logic icache_flush,
  output logic dcache_flush,
  output logic fence_busy
);

  logic fence_start;
  logic flush_pulse;
  logic iflushed;
  logic dflushed;

  assign fence_start = issue & is_fence;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      flush_pulse <= 1'b0;
    end else begin
      flush_pulse <= fence_start;
    end
  end

  // Done flags may come back in either order
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      iflushed <= 1'b1;
      dflushed <= 1'b1;
    end else if (fence_start) begin
      iflushed <= 1'b0;
      dflushed <= 1'b0;
    end else begin
      if (iflush_done) begin
        iflushed <= 1'b1;
      end
      if (dflush_done) begin
        dflushed <= 1'b1;
      end
    end
  end

  assign icache_flush = flush_pulse;
  assign dcache_flush = flush_pulse;
  assign fence_busy   = ~(iflushed & dflushed);

endmodule

//--- hw/dispatch_latch.sv
// Issue decision and the decode-to-execute pipeline register.
// Accepts an instruction when no hazard holds it back, registers the
// execute payload on issue and holds it while execute stalls. A fence
// issues but is never presented to execute.
`timescale 1ns/1ps

module dispatch_latch (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  instr_valid,
  input  logic                  flush,
  input  logic                  stall_ex,
  input  logic                  wb_conflict,
  input  logic                  fence_busy,
  input  decode_pkg::fu_class_t fu_class,
  input  decode_pkg::alu_op_t   alu_op,
  input  decode_pkg::reg_idx_t  rd,
  input  logic                  wen,
  input  logic                  is_jump,
  input  logic                  is_fence,
  input  decode_pkg::word_t     port_a,
  input  decode_pkg::word_t     port_b,
  input  decode_pkg::word_t     store_data,
  input  decode_pkg::word_t     jump_target,
  input  decode_pkg::word_t     pc4,
  output logic                  instr_ready,
  output logic                  issue,
  output logic                  ex_valid,
  output decode_pkg::fu_class_t ex_class,
  output decode_pkg::alu_op_t   ex_alu_op,
  output decode_pkg::reg_idx_t  ex_rd,
  output logic                  ex_wen,
  output decode_pkg::word_t     ex_port_a,
  output decode_pkg::word_t     ex_port_b,
  output decode_pkg::word_t     ex_store_data,
  output decode_pkg::word_t     ex_pc4,
  output logic                  ex_is_jump,
  output decode_pkg::word_t     ex_jump_target
);

  assign instr_ready = ~(flush | stall_ex | wb_conflict | fence_busy);
  assign issue       = instr_valid & instr_ready;

  // Flush wins, stall holds, otherwise valid follows issue
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid <= 1'b0;
    end else if (flush) begin
      ex_valid <= 1'b0;
    end else if (!stall_ex) begin
      ex_valid <= issue & ~is_fence;
    end
  end

  always_ff @(posedge CLK) begin
    if (issue) begin
      ex_class       <= fu_class;
      ex_alu_op      <= alu_op;
      ex_rd          <= rd;
      ex_wen         <= wen;
      ex_port_a      <= port_a;
      ex_port_b      <= port_b;
      ex_store_data  <= store_data;
      ex_pc4         <= pc4;
      ex_is_jump     <= is_jump;
      ex_jump_target <= jump_target;
    end
  end

endmodule

//--- hw/decode_stage.sv
// Top of the RV32IM decode stage.
// Takes instructions from fetch under valid/ready, reads operands
// from the register file and bypass network, and dispatches one
// registered instruction per cycle toward execute.
`timescale 1ns/1ps

module decode_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  instr_valid,
  input  decode_pkg::word_t     instr,
  input  decode_pkg::word_t     pc,
  input  decode_pkg::word_t     pc4,
  output logic                  instr_ready,
  output decode_pkg::reg_idx_t  rs1_idx,
  output decode_pkg::reg_idx_t  rs2_idx,
  input  decode_pkg::word_t     rs1_data,
  input  decode_pkg::word_t     rs2_data,
  input  logic                  rs1_bypass_ena,
  input  decode_pkg::word_t     rs1_bypass_data,
  input  logic                  rs2_bypass_ena,
  input  decode_pkg::word_t     rs2_bypass_data,
  output logic                  ex_valid,
  output decode_pkg::fu_class_t ex_class,
  output decode_pkg::alu_op_t   ex_alu_op,
  output decode_pkg::reg_idx_t  ex_rd,
  output logic                  ex_wen,
  output decode_pkg::word_t     ex_port_a,
  output decode_pkg::word_t     ex_port_b,
  output decode_pkg::word_t     ex_store_data,
  output decode_pkg::word_t     ex_pc4,
  output logic                  ex_is_jump,
  output decode_pkg::word_t     ex_jump_target,
  input  logic                  stall_ex,
  input  logic                  flush,
  output logic                  icache_flush,
  output logic                  dcache_flush,
  input  logic                  iflush_done,
  input  logic                  dflush_done
);

  import decode_pkg::*;

  fu_class_t  fu_class;
  alu_op_t    alu_op;
  src_a_sel_t src_a_sel;
  src_b_sel_t src_b_sel;
  reg_idx_t   rd;
  logic       wen;
  logic       is_jump;
  logic       is_jalr;
  logic       is_fence;
  word_t      imm;
  word_t      imm_j;
  word_t      port_a;
  word_t      port_b;
  word_t      store_data;
  word_t      jump_target;
  logic       issue;
  logic       wb_conflict;
  logic       fence_busy;

  // Opcode, store and illegal flags are not needed past decode here
  instr_decoder u_decoder (
    .instr     (instr),
    .opcode    (),
    .fu_class  (fu_class),
    .alu_op    (alu_op),
    .src_a_sel (src_a_sel),
    .src_b_sel (src_b_sel),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rd        (rd),
    .wen       (wen),
    .is_jump   (is_jump),
    .is_jalr   (is_jalr),
    .is_store  (),
    .is_fence  (is_fence),
    .illegal   (),
    .imm       (imm),
    .imm_j     (imm_j)
  );

  operand_select u_operands (
    .src_a_sel       (src_a_sel),
    .src_b_sel       (src_b_sel),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .rs1_bypass_ena  (rs1_bypass_ena),
    .rs2_bypass_ena  (rs2_bypass_ena),
    .rs1_bypass_data (rs1_bypass_data),
    .rs2_bypass_data (rs2_bypass_data),
    .pc              (pc),
    .imm             (imm),
    .imm_j           (imm_j),
    .is_jalr         (is_jalr),
    .port_a          (port_a),
    .port_b          (port_b),
    .store_data      (store_data),
    .jump_target     (jump_target)
  );

  wb_conflict_tracker u_wb_tracker (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue       (issue),
    .fu_class    (fu_class),
    .port_a      (port_a),
    .port_b      (port_b),
    .wb_conflict (wb_conflict)
  );

  fence_tracker u_fence (
    .CLK          (CLK),
    .nRST         (nRST),
    .issue        (issue),
    .is_fence     (is_fence),
    .iflush_done  (iflush_done),
    .dflush_done  (dflush_done),
    .icache_flush (icache_flush),
    .dcache_flush (dcache_flush),
    .fence_busy   (fence_busy)
  );

  dispatch_latch u_dispatch (
    .CLK            (CLK),
    .nRST           (nRST),
    .instr_valid    (instr_valid),
    .flush          (flush),
    .stall_ex       (stall_ex),
    .wb_conflict    (wb_conflict),
    .fence_busy     (fence_busy),
    .fu_class       (fu_class),
    .alu_op         (alu_op),
    .rd             (rd),
    .wen            (wen),
    .is_jump        (is_jump),
    .is_fence       (is_fence),
    .port_a         (port_a),
    .port_b         (port_b),
    .store_data     (store_data),
    .jump_target    (jump_target),
    .pc4            (pc4),
    .instr_ready    (instr_ready),
    .issue          (issue),
    .ex_valid       (ex_valid),
    .ex_class       (ex_class),
    .ex_alu_op      (ex_alu_op),
    .ex_rd          (ex_rd),
    .ex_wen         (ex_wen),
    .ex_port_a      (ex_port_a),
    .ex_port_b      (ex_port_b),
    .ex_store_data  (ex_store_data),
    .ex_pc4         (ex_pc4),
    .ex_is_jump     (ex_is_jump),
    .ex_jump_target (ex_jump_target)
  );

endmodule

//--- verification/tb_decode_stage.sv
// Directed testbench for the RV32IM decode stage.
// Builds instructions from their fields, drives them through the fetch
// handshake and checks the registered execute payload against values
// worked out from the encodings and a small register file model.
// Covers ALU ops, bypass, jumps, write-port conflicts, stall/flush and
// FENCE.I with cache responses in either order.
`timescale 1ns/1ps

module tb_decode_stage;

  import decode_pkg::*;

  // About 160 cycles of tests, with generous margin
  localparam int MAX_CYCLES = 400;

  logic       CLK;
  logic       nRST;
  logic       instr_valid;
  word_t      instr;
  word_t      pc;
  word_t      pc4;
  logic       instr_ready;
  reg_idx_t   rs1_idx;
  reg_idx_t   rs2_idx;
  word_t      rs1_data;
  word_t      rs2_data;
  logic       rs1_bypass_ena;
  word_t      rs1_bypass_data;
  logic       rs2_bypass_ena;
  word_t      rs2_bypass_data;
  logic       ex_valid;
  fu_class_t  ex_class;
  alu_op_t    ex_alu_op;
  reg_idx_t   ex_rd;
  logic       ex_wen;
  word_t      ex_port_a;
  word_t      ex_port_b;
  word_t      ex_store_data;
  word_t      ex_pc4;
  logic       ex_is_jump;
  word_t      ex_jump_target;
  logic       stall_ex;
  logic       flush;
  logic       icache_flush;
  logic       dcache_flush;
  logic       iflush_done;
  logic       dflush_done;

  word_t      regs [32];
  integer     seed;
  int         errors;
  int         tests_run;
  int         tests_failed;
  int         cycles = 0;

  decode_stage DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic word_t sext(input word_t v, input int bits);
    return word_t'($signed(v << (32 - bits)) >>> (32 - bits));
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                   input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic report_mismatch(input string what, input word_t got, input word_t exp);
    $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic report_test(input string name, input int start);
    tests_run++;
    if (errors == start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, errors - start);
    end
  endtask

  // Register file reads follow the index fields of the instruction
  task automatic drive_instr(input word_t i, input word_t p);
    instr_valid <= 1'b1;
    instr       <= i;
    pc          <= p;
    pc4         <= p + 32'd4;
    rs1_data    <= regs[i[19:15]];
    rs2_data    <= regs[i[24:20]];
  endtask

  // Returns on the accept edge
  task automatic issue_bypassed(input word_t i, input word_t p, input logic e1,
                                input word_t d1, input logic e2, input word_t d2);
    @(posedge CLK);
    drive_instr(i, p);
    rs1_bypass_ena  <= e1;
    rs1_bypass_data <= d1;
    rs2_bypass_ena  <= e2;
    rs2_bypass_data <= d2;
    @(negedge CLK);
    // Register file indexes come straight from the rs1 and rs2 fields
    if (rs1_idx !== i[19:15]) report_mismatch("rs1_idx", 32'(rs1_idx), 32'(i[19:15]));
    if (rs2_idx !== i[24:20]) report_mismatch("rs2_idx", 32'(rs2_idx), 32'(i[24:20]));
    while (!instr_ready) begin
      @(negedge CLK);
    end
    @(posedge CLK);
    instr_valid    <= 1'b0;
    rs1_bypass_ena <= 1'b0;
    rs2_bypass_ena <= 1'b0;
  endtask

  task automatic issue_instr(input word_t i, input word_t p);
    issue_bypassed(i, p, 1'b0, 32'd0, 1'b0, 32'd0);
  endtask

  task automatic check_payload(input fu_class_t c, input alu_op_t op, input reg_idx_t rd,
                               input word_t a, input word_t b, input logic w);
    @(negedge CLK);
    if (ex_valid !== 1'b1) report_mismatch("ex_valid", 32'(ex_valid), 32'd1);
    if (ex_class !== c) report_mismatch("ex_class", 32'(ex_class), 32'(c));
    if (ex_alu_op !== op) report_mismatch("ex_alu_op", 32'(ex_alu_op), 32'(op));
    if (ex_rd !== rd) report_mismatch("ex_rd", 32'(ex_rd), 32'(rd));
    if (ex_wen !== w) report_mismatch("ex_wen", 32'(ex_wen), 32'(w));
    if (ex_port_a !== a) report_mismatch("ex_port_a", ex_port_a, a);
    if (ex_port_b !== b) report_mismatch("ex_port_b", ex_port_b, b);
  endtask

  task automatic check_jump(input word_t target, input word_t ret);
    @(negedge CLK);
    if (ex_valid !== 1'b1) report_mismatch("ex_valid", 32'(ex_valid), 32'd1);
    if (ex_is_jump !== 1'b1) report_mismatch("ex_is_jump", 32'(ex_is_jump), 32'd1);
    if (ex_wen !== 1'b1) report_mismatch("ex_wen on jump", 32'(ex_wen), 32'd1);
    if (ex_jump_target !== target) report_mismatch("ex_jump_target", ex_jump_target, target);
    if (ex_pc4 !== ret) report_mismatch("ex_pc4", ex_pc4, ret);
  endtask

  // Holds the current instruction valid and records instr_ready per edge
  task automatic sample_ready(input int n, output logic [17:0] seen);
    seen = '0;
    for (int k = 0; k < n; k++) begin
      @(negedge CLK);
      seen[k] = instr_ready;
      @(posedge CLK);
    end
    instr_valid <= 1'b0;
  endtask

  task automatic reset_values();
    int start;
    start = errors;
    @(negedge CLK);
    if (ex_valid !== 1'b0) report_mismatch("ex_valid after reset", 32'(ex_valid), 32'd0);
    if (icache_flush !== 1'b0) report_mismatch("icache_flush", 32'(icache_flush), 32'd0);
    if (dcache_flush !== 1'b0) report_mismatch("dcache_flush", 32'(dcache_flush), 32'd0);
    if (instr_ready !== 1'b1) report_mismatch("instr_ready", 32'(instr_ready), 32'd1);
    report_test("reset values", start);
  endtask

  task automatic alu_ops();
    word_t       w;
    word_t       u;
    word_t       p;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    logic [11:0] imm12;
    int          start;
    start = errors;
    for (int k = 0; k < 4; k++) begin
      w = rand_word();
      u = rand_word();
      p = rand_word();
      p[1:0] = 2'b00;
      rs1 = w[4:0];
      rs2 = w[9:5];
      rd = w[14:10];
      imm12 = w[26:15];
      issue_instr(i_type(imm12, rs1, 3'b000, rd, OP_IMM), p);
      check_payload(FU_ALU, ADD, rd, regs[rs1], sext(32'(imm12), 12), 1'b1);
      issue_instr(i_type(imm12, rs1, 3'b100, rd, OP_IMM), p);
      check_payload(FU_ALU, XOR, rd, regs[rs1], sext(32'(imm12), 12), 1'b1);
      issue_instr(r_type(7'b0000000, rs2, rs1, 3'b000, rd, OP), p);
      check_payload(FU_ALU, ADD, rd, regs[rs1], regs[rs2], 1'b1);
      issue_instr(r_type(7'b0100000, rs2, rs1, 3'b000, rd, OP), p);
      check_payload(FU_ALU, SUB, rd, regs[rs1], regs[rs2], 1'b1);
      issue_instr(u_type(u[19:0], rd, LUI), p);
      check_payload(FU_ALU, ADD, rd, 32'd0, {u[19:0], 12'b0}, 1'b1);
      issue_instr(u_type(u[19:0], rd, AUIPC), p);
      check_payload(FU_ALU, ADD, rd, p, {u[19:0], 12'b0}, 1'b1);
    end
    report_test("alu immediate and register ops", start);
  endtask

  task automatic bypass_priority();
    word_t       b1;
    word_t       b2;
    logic [11:0] imm12;
    int          start;
    start = errors;
    b1 = rand_word();
    b2 = rand_word();
    imm12 = b2[31:20];
    issue_bypassed(r_type(7'd0, 5'd8, 5'd7, 3'b000, 5'd9, OP), 32'h40, 1'b1, b1, 1'b0, b2);
    check_payload(FU_ALU, ADD, 5'd9, b1, regs[8], 1'b1);
    issue_bypassed(r_type(7'd0, 5'd8, 5'd7, 3'b000, 5'd9, OP), 32'h44, 1'b0, b1, 1'b1, b2);
    check_payload(FU_ALU, ADD, 5'd9, regs[7], b2, 1'b1);
    issue_bypassed(r_type(7'd0, 5'd8, 5'd7, 3'b000, 5'd9, OP), 32'h48, 1'b1, b1, 1'b1, b2);
    check_payload(FU_ALU, ADD, 5'd9, b1, b2, 1'b1);
    // SW carries funct3 as the op, and imm[4:0] sits in the rd field
    issue_bypassed(s_type(imm12, 5'd8, 5'd7, 3'b010), 32'h4c, 1'b0, b1, 1'b1, b2);
    check_payload(FU_LSU, alu_op_t'(4'd2), imm12[4:0], regs[7], sext(32'(imm12), 12), 1'b0);
    if (ex_store_data !== b2) report_mismatch("ex_store_data", ex_store_data, b2);
    issue_bypassed(s_type(imm12, 5'd8, 5'd7, 3'b010), 32'h50, 1'b1, b1, 1'b0, b2);
    check_payload(FU_LSU, alu_op_t'(4'd2), imm12[4:0], b1, sext(32'(imm12), 12), 1'b0);
    if (ex_store_data !== regs[8]) report_mismatch("ex_store_data", ex_store_data, regs[8]);
    report_test("bypass priority", start);
  endtask

  task automatic jump_targets();
    word_t       w;
    word_t       p;
    logic [20:0] imm21;
    logic [11:0] imm12;
    reg_idx_t    rs1;
    int          start;
    start = errors;
    for (int k = 0; k < 2; k++) begin
      w = rand_word();
      p = rand_word();
      p[1:0] = 2'b00;
      imm21 = {w[20:1], 1'b0};
      imm12 = w[31:20];
      rs1 = w[25:21];
      issue_instr(j_type(imm21, 5'd1), p);
      check_jump(p + sext(32'(imm21), 21), p + 32'd4);
      issue_instr(i_type(imm12, rs1, 3'b000, 5'd1, JALR), p);
      check_jump((regs[rs1] + sext(32'(imm12), 12)) & 32'hffff_fffe, p + 32'd4);
    end
    report_test("jump targets", start);
  endtask

  task automatic write_port_conflicts();
    word_t       alu;
    logic [17:0] seen;
    int          start;
    start = errors;
    alu = r_type(7'd0, 5'd2, 5'd1, 3'b000, 5'd3, OP);
    // MUL result lands 3 cycles after issue
    issue_instr(r_type(7'b0000001, 5'd5, 5'd4, 3'b000, 5'd6, OP), 32'h100);
    drive_instr(alu, 32'h104);
    sample_ready(4, seen);
    if (seen[3:0] !== 4'b1011) report_mismatch("ready after MUL", 32'(seen[3:0]), 32'hb);
    issue_instr(r_type(7'b0000001, 5'd5, 5'd4, 3'b100, 5'd6, OP), 32'h108);
    drive_instr(alu, 32'h10c);
    sample_ready(18, seen);
    if (seen !== 18'h2ffff) report_mismatch("ready after DIV", 32'(seen), 32'h2ffff);
    // x0 as divisor reads zero
    issue_instr(r_type(7'b0000001, 5'd0, 5'd4, 3'b100, 5'd6, OP), 32'h110);
    drive_instr(alu, 32'h114);
    sample_ready(18, seen);
    if (seen !== 18'h3ffff) report_mismatch("ready after DIV by 0", 32'(seen), 32'h3ffff);
    report_test("write-port conflicts", start);
  endtask

  task automatic stall_and_flush();
    int start;
    start = errors;
    issue_instr(r_type(7'd0, 5'd11, 5'd10, 3'b000, 5'd12, OP), 32'h200);
    stall_ex <= 1'b1;
    drive_instr(r_type(7'b0100000, 5'd14, 5'd13, 3'b000, 5'd15, OP), 32'h204);
    repeat (3) begin
      @(negedge CLK);
      if (instr_ready !== 1'b0) report_mismatch("instr_ready in stall", 32'(instr_ready), 0);
      if (ex_valid !== 1'b1) report_mismatch("ex_valid in stall", 32'(ex_valid), 32'd1);
      if (ex_port_a !== regs[10]) report_mismatch("ex_port_a in stall", ex_port_a, regs[10]);
      if (ex_port_b !== regs[11]) report_mismatch("ex_port_b in stall", ex_port_b, regs[11]);
      if (ex_rd !== 5'd12) report_mismatch("ex_rd in stall", 32'(ex_rd), 32'd12);
      @(posedge CLK);
    end
    stall_ex <= 1'b0;
    flush    <= 1'b1;
    @(negedge CLK);
    if (instr_ready !== 1'b0) report_mismatch("instr_ready in flush", 32'(instr_ready), 0);
    @(posedge CLK);
    flush <= 1'b0;
    @(negedge CLK);
    if (ex_valid !== 1'b0) report_mismatch("ex_valid after flush", 32'(ex_valid), 32'd0);
    // Held instruction goes through once flush drops
    @(posedge CLK);
    instr_valid <= 1'b0;
    check_payload(FU_ALU, SUB, 5'd15, regs[13], regs[14], 1'b1);
    @(posedge CLK);
    @(negedge CLK);
    if (ex_valid !== 1'b0) report_mismatch("ex_valid when idle", 32'(ex_valid), 32'd0);
    report_test("stall and flush", start);
  endtask

  // Cache model answers the flush pulse after the given number of cycles
  task automatic fence_round(input int i_delay, input int d_delay);
    int last;
    last = (i_delay > d_delay) ? i_delay : d_delay;
    issue_instr(i_type(12'd0, 5'd0, 3'b001, 5'd0, MISCMEM), 32'h300);
    for (int c = 0; c <= last + 1; c++) begin
      iflush_done <= (c == i_delay);
      dflush_done <= (c == d_delay);
      @(negedge CLK);
      if (icache_flush !== (c == 0)) report_mismatch("icache_flush", 32'(icache_flush), 32'(c == 0));
      if (dcache_flush !== (c == 0)) report_mismatch("dcache_flush", 32'(dcache_flush), 32'(c == 0));
      if (ex_valid !== 1'b0) report_mismatch("ex_valid on fence", 32'(ex_valid), 32'd0);
      if (instr_ready !== (c > last)) begin
        report_mismatch("instr_ready on fence", 32'(instr_ready), 32'(c > last));
      end
      @(posedge CLK);
    end
  endtask

  task automatic fence_handshake();
    int start;
    start = errors;
    fence_round(2, 5);
    fence_round(6, 3);
    fence_round(4, 4);
    report_test("fence.i handshake", start);
  endtask

  initial begin
    seed            = 32'h33b0_e174;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    nRST            = 1'b0;
    instr_valid     = 1'b0;
    instr           = '0;
    pc              = '0;
    pc4             = '0;
    rs1_data        = '0;
    rs2_data        = '0;
    rs1_bypass_ena  = 1'b0;
    rs1_bypass_data = '0;
    rs2_bypass_ena  = 1'b0;
    rs2_bypass_data = '0;
    stall_ex        = 1'b0;
    flush           = 1'b0;
    iflush_done     = 1'b0;
    dflush_done     = 1'b0;
    // Odd values keep divisors nonzero and avoid the overflow divide
    regs[0] = '0;
    for (int k = 1; k < 32; k++) begin
      regs[k] = rand_word() | 32'd1;
    end
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    reset_values();
    alu_ops();
    bypass_priority();
    jump_targets();
    write_port_conflicts();
    stall_and_flush();
    fence_handshake();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- decode_stage.f
hw/decode_pkg.sv
hw/instr_decoder.sv
hw/operand_select.sv
hw/wb_conflict_tracker.sv
hw/fence_tracker.sv
hw/dispatch_latch.sv
hw/decode_stage.sv
verification/tb_decode_stage.sv

//--- Makefile
# Verilator build and run of the decode stage testbench
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= decode_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } index($$0, "$(PASS_MSG)") { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
